//--- design/mps_bus_pkg.sv
package mps_bus_pkg;

	// Write address and write data travel as one beat
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
	} axil_aw_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [31:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
	} axil_r_t;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- design/mps_uart_pkg.sv
package mps_uart_pkg;

	typedef enum logic [1:0] {
		REG_DATA = 2'd0,
		REG_STATUS = 2'd1,
		REG_CTRL = 2'd2,
		REG_DIV = 2'd3
	} reg_sel_e;

	// 16 byte stride per port
	localparam int ADDR_REG_LSB = 2;
	localparam int ADDR_PORT_LSB = 4;

	typedef struct packed {
		logic valid;
		logic write;
		logic [3:0] port;
		reg_sel_e sel;
		logic [15:0] wdata;
	} reg_req_t;

	typedef struct packed {
		logic valid;
		logic [15:0] data;
	} port_rsp_t;

	typedef logic [7:0] tx_byte_t;

	typedef struct packed {
		logic ferr; // Stop bit was low
		logic [7:0] data;
	} rx_byte_t;

	localparam int STAT_RX_AVAIL = 0;
	localparam int STAT_TX_FULL = 1;
	localparam int STAT_TX_EMPTY = 2;
	localparam int STAT_FRAME_ERR = 3;
	localparam int STAT_RX_OVERRUN = 4;

	localparam int CTRL_RX_IE = 0;
	localparam int CTRL_TX_IE = 1;

endpackage

//--- design/mps_sync_fifo.sv
`timescale 1ns/1ns

module mps_sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic aclk,
	input logic rstni,
	input logic push_i,
	input payload_t din_i,
	input logic pop_i,
	output payload_t dout_o,
	output logic empty_o,
	output logic full_o
);

localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

payload_t mem [DEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [CW-1:0] count;
logic do_push;
logic do_pop;

assign do_push = push_i && !full_o;
assign do_pop = pop_i && !empty_o;
assign empty_o = (count == '0);
assign full_o = (count == CW'(DEPTH));
assign dout_o = mem[rd_ptr]; // Show-ahead head

always_ff @(posedge aclk) begin
	if (do_push)
		mem[wr_ptr] <= din_i;
end

always_ff @(posedge aclk or negedge rstni) begin
	if (!rstni) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (do_push)
			wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		if (do_push && !do_pop)
			count <= count + 1'b1;
		else if (do_pop && !do_push)
			count <= count - 1'b1;
	end
end

endmodule

//--- design/mps_axil_front.sv
`timescale 1ns/1ns

module mps_axil_front import mps_bus_pkg::*; import mps_uart_pkg::*; #(
	parameter int PORT_NUM = 4
) (
	input logic aclk,
	input logic rstni,
	input logic aw_valid_i,
	input axil_aw_t aw_i,
	output logic aw_ready_o,
	input logic ar_valid_i,
	input axil_ar_t ar_i,
	output logic ar_ready_o,
	output logic b_valid_o,
	output axil_b_t b_o,
	input logic b_ready_i,
	output logic r_valid_o,
	output axil_r_t r_o,
	input logic r_ready_i,
	input logic [15:0] rd_data_i,
	output reg_req_t req_o
);

typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_RESP} state_e;

state_e state;
logic rdy_q;
logic wr_q;
logic err_q;
logic aw_hs;
logic ar_hs;
logic rsp_hs;
logic [3:0] aw_port;
logic [3:0] ar_port;
logic aw_err;
logic ar_err;

assign aw_ready_o = rdy_q;
assign ar_ready_o = rdy_q && !aw_valid_i; // Write wins a tie
assign aw_hs = aw_valid_i && aw_ready_o;
assign ar_hs = ar_valid_i && ar_ready_o;
assign rsp_hs = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i);

assign aw_port = aw_i.addr[ADDR_PORT_LSB +: 4];
assign ar_port = ar_i.addr[ADDR_PORT_LSB +: 4];
assign aw_err = aw_port >= 4'(PORT_NUM); // Global word is read only
assign ar_err = ar_port > 4'(PORT_NUM);

always_ff @(posedge aclk or negedge rstni) begin
	if (!rstni) begin
		state <= ST_IDLE;
		rdy_q <= 1'b0;
		wr_q <= 1'b0;
		err_q <= 1'b0;
		req_o <= '0;
		b_valid_o <= 1'b0;
		r_valid_o <= 1'b0;
	end else begin
		case (state)
			ST_IDLE: begin
				rdy_q <= 1'b1;
				if (aw_hs) begin
					rdy_q <= 1'b0;
					wr_q <= 1'b1;
					err_q <= aw_err;
					req_o.valid <= !aw_err;
					req_o.write <= 1'b1;
					req_o.port <= aw_port;
					req_o.sel <= reg_sel_e'(aw_i.addr[ADDR_REG_LSB +: 2]);
					req_o.wdata <= aw_i.data[15:0];
					state <= ST_REQ;
				end else if (ar_hs) begin
					rdy_q <= 1'b0;
					wr_q <= 1'b0;
					err_q <= ar_err;
					req_o.valid <= !ar_err;
					req_o.write <= 1'b0;
					req_o.port <= ar_port;
					req_o.sel <= reg_sel_e'(ar_i.addr[ADDR_REG_LSB +: 2]);
					req_o.wdata <= '0;
					state <= ST_REQ;
				end
			end
			ST_REQ: begin
				req_o.valid <= 1'b0; // One cycle broadcast
				if (wr_q) begin
					b_valid_o <= 1'b1;
					state <= ST_RESP;
				end else begin
					state <= ST_WAIT; // Merge block registers the reply
				end
			end
			ST_WAIT: begin
				r_valid_o <= 1'b1;
				state <= ST_RESP;
			end
			ST_RESP: begin
				if (rsp_hs) begin
					b_valid_o <= 1'b0;
					r_valid_o <= 1'b0;
					rdy_q <= 1'b1;
					state <= ST_IDLE;
				end
			end
			default: state <= ST_IDLE;
		endcase
	end
end

always_ff @(posedge aclk) begin
	if (state == ST_REQ)
		b_o.resp <= err_q ? RESP_SLVERR : RESP_OKAY;
	if (state == ST_WAIT) begin
		r_o.data <= {16'h0000, rd_data_i};
		r_o.resp <= err_q ? RESP_SLVERR : RESP_OKAY;
	end
end

endmodule

//--- design/mps_uart_port.sv
`timescale 1ns/1ns

module mps_uart_port import mps_uart_pkg::*; #(
	parameter int PORT_ID = 0,
	parameter int FIFO_DEPTH = 4,
	parameter int RESET_DIV = 16
) (
	input logic aclk,
	input logic rstni,
	input reg_req_t req_i,
	input logic rxd_i,
	output port_rsp_t rsp_o,
	output logic txd_o,
	output logic irq_o
);

logic hit;
logic data_wr;
logic data_rd;
logic stat_rd;
logic [1:0] ctrl_q;
logic [15:0] div_q;
logic ferr_q;
logic ovr_q;
logic [15:0] status;

tx_byte_t tx_head;
logic tx_fifo_empty;
logic tx_full;
logic tx_pop;
logic tx_busy;
logic tx_tick;
logic tx_empty;
logic [8:0] tx_shift;
logic [15:0] tx_cnt;
logic [3:0] tx_nbits;

rx_byte_t rx_head;
rx_byte_t rx_din;
logic rx_empty;
logic rx_full;
logic rx_push;
logic [1:0] rx_sync;
logic rx_prev;
logic rx_busy;
logic rx_tick;
logic rx_done;
logic [15:0] rx_cnt;
logic [15:0] rx_lim;
logic [3:0] rx_nbits;
logic [7:0] rx_shift;

assign hit = req_i.valid && (req_i.port == 4'(PORT_ID));
assign data_wr = hit && req_i.write && (req_i.sel == REG_DATA);
assign data_rd = hit && !req_i.write && (req_i.sel == REG_DATA);
assign stat_rd = hit && !req_i.write && (req_i.sel == REG_STATUS);

assign tx_empty = tx_fifo_empty && !tx_busy;
assign tx_pop = !tx_busy && !tx_fifo_empty;
assign tx_tick = tx_busy && (tx_cnt == div_q - 16'd1);

assign rx_lim = (rx_nbits == 4'd0) ? {1'b0, div_q[15:1]} : div_q; // Half bit to mid start
assign rx_tick = rx_busy && (rx_cnt == rx_lim - 16'd1);
assign rx_done = rx_tick && (rx_nbits == 4'd9);
assign rx_push = rx_done && !rx_full;
assign rx_din = '{ferr: !rx_sync[1], data: rx_shift};

mps_sync_fifo #(.payload_t(tx_byte_t), .DEPTH(FIFO_DEPTH)) tx_fifo_i (
	.aclk(aclk),
	.rstni(rstni),
	.push_i(data_wr),
	.din_i(req_i.wdata[7:0]),
	.pop_i(tx_pop),
	.dout_o(tx_head),
	.empty_o(tx_fifo_empty),
	.full_o(tx_full)
);

mps_sync_fifo #(.payload_t(rx_byte_t), .DEPTH(FIFO_DEPTH)) rx_fifo_i (
	.aclk(aclk),
	.rstni(rstni),
	.push_i(rx_push),
	.din_i(rx_din),
	.pop_i(data_rd),
	.dout_o(rx_head),
	.empty_o(rx_empty),
	.full_o(rx_full)
);

always_ff @(posedge aclk or negedge rstni) begin
	if (!rstni) begin
		ctrl_q <= '0;
		div_q <= 16'(RESET_DIV);
		ferr_q <= 1'b0;
		ovr_q <= 1'b0;
	end else begin
		if (hit && req_i.write && (req_i.sel == REG_CTRL))
			ctrl_q <= req_i.wdata[1:0];
		if (hit && req_i.write && (req_i.sel == REG_DIV))
			div_q <= req_i.wdata;
		if (rx_done && !rx_sync[1])
			ferr_q <= 1'b1;
		else if (stat_rd)
			ferr_q <= 1'b0;
		if (rx_done && rx_full)
			ovr_q <= 1'b1; // Byte is lost
		else if (stat_rd)
			ovr_q <= 1'b0;
	end
end

// Transmitter, start bit driven on load
always_ff @(posedge aclk or negedge rstni) begin
	if (!rstni) begin
		tx_busy <= 1'b0;
		txd_o <= 1'b1;
		tx_cnt <= '0;
		tx_nbits <= '0;
	end else if (tx_pop) begin
		tx_busy <= 1'b1;
		txd_o <= 1'b0;
		tx_cnt <= '0;
		tx_nbits <= '0;
	end else if (tx_tick) begin
		tx_cnt <= '0;
		if (tx_nbits == 4'd9) begin
			tx_busy <= 1'b0; // End of stop bit
		end else begin
			txd_o <= tx_shift[0];
			tx_nbits <= tx_nbits + 4'd1;
		end
	end else if (tx_busy) begin
		tx_cnt <= tx_cnt + 16'd1;
	end
end

always_ff @(posedge aclk) begin
	if (tx_pop)
		tx_shift <= {1'b1, tx_head}; // Stop bit above data
	else if (tx_tick && (tx_nbits != 4'd9))
		tx_shift <= {1'b1, tx_shift[8:1]};
end

// Receiver
always_ff @(posedge aclk or negedge rstni) begin
	if (!rstni) begin
		rx_sync <= 2'b11;
		rx_prev <= 1'b1;
		rx_busy <= 1'b0;
		rx_cnt <= '0;
		rx_nbits <= '0;
	end else begin
		rx_sync <= {rx_sync[0], rxd_i};
		rx_prev <= rx_sync[1];
		if (!rx_busy) begin
			if (rx_prev && !rx_sync[1]) begin // Falling edge of start
				rx_busy <= 1'b1;
				rx_cnt <= '0;
				rx_nbits <= '0;
			end
		end else if (rx_tick) begin
			rx_cnt <= '0;
			rx_nbits <= rx_nbits + 4'd1;
			if ((rx_nbits == 4'd0 && rx_sync[1]) || rx_nbits == 4'd9)
				rx_busy <= 1'b0; // Glitch or frame done
		end else begin
			rx_cnt <= rx_cnt + 16'd1;
		end
	end
end

always_ff @(posedge aclk) begin
	if (rx_tick && (rx_nbits != 4'd0) && (rx_nbits != 4'd9))
		rx_shift <= {rx_sync[1], rx_shift[7:1]}; // LSB first
end

always_comb begin
	status = '0;
	status[STAT_RX_AVAIL] = !rx_empty;
	status[STAT_TX_FULL] = tx_full;
	status[STAT_TX_EMPTY] = tx_empty;
	status[STAT_FRAME_ERR] = ferr_q;
	status[STAT_RX_OVERRUN] = ovr_q;
	rsp_o.valid = hit && !req_i.write;
	case (req_i.sel)
		REG_DATA: rsp_o.data = rx_empty ? 16'h0000 : {7'b0, rx_head.ferr, rx_head.data};
		REG_STATUS: rsp_o.data = status;
		REG_CTRL: rsp_o.data = {14'b0, ctrl_q};
		default: rsp_o.data = div_q;
	endcase
end

assign irq_o = (!rx_empty && ctrl_q[CTRL_RX_IE]) || (tx_empty && ctrl_q[CTRL_TX_IE]);

endmodule

//--- design/mps_read_merge.sv
`timescale 1ns/1ns

module mps_read_merge import mps_uart_pkg::*; #(
	parameter int PORT_NUM = 4
) (
	input logic aclk,
	input logic rstni,
	input reg_req_t req_i,
	input port_rsp_t rsp_i [PORT_NUM],
	input logic [PORT_NUM-1:0] irq_i,
	output logic [15:0] rd_data_o,
	output logic intr_o
);

logic glob_rd;
logic [15:0] port_data;

assign glob_rd = req_i.valid && !req_i.write && (req_i.port == 4'(PORT_NUM));

// At most one port replies
always_comb begin
	port_data = '0;
	for (int k = 0; k < PORT_NUM; k++) begin
		if (rsp_i[k].valid)
			port_data = port_data | rsp_i[k].data;
	end
end

always_ff @(posedge aclk) begin
	if (glob_rd)
		rd_data_o <= (req_i.sel == REG_DATA) ? 16'(irq_i) : 16'h0000;
	else
		rd_data_o <= port_data;
end

always_ff @(posedge aclk or negedge rstni) begin
	if (!rstni)
		intr_o <= 1'b0;
	else
		intr_o <= |irq_i;
end

endmodule

//--- design/mps_top.sv
`timescale 1ns/1ns

module mps_top import mps_bus_pkg::*; import mps_uart_pkg::*; #(
	parameter int PORT_NUM = 4,
	parameter int FIFO_DEPTH = 4,
	parameter int RESET_DIV = 16
) (
	input logic aclk,
	input logic rstni,
	input logic aw_valid_i,
	input axil_aw_t aw_i,
	output logic aw_ready_o,
	input logic ar_valid_i,
	input axil_ar_t ar_i,
	output logic ar_ready_o,
	output logic b_valid_o,
	output axil_b_t b_o,
	input logic b_ready_i,
	output logic r_valid_o,
	output axil_r_t r_o,
	input logic r_ready_i,
	input logic [PORT_NUM-1:0] rxd_i,
	output logic [PORT_NUM-1:0] txd_o,
	output logic intr_o
);

reg_req_t req;
port_rsp_t port_rsp [PORT_NUM];
logic [PORT_NUM-1:0] port_irq;
logic [15:0] rd_data;

mps_axil_front #(.PORT_NUM(PORT_NUM)) front_i (
	.aclk(aclk),
	.rstni(rstni),
	.aw_valid_i(aw_valid_i),
	.aw_i(aw_i),
	.aw_ready_o(aw_ready_o),
	.ar_valid_i(ar_valid_i),
	.ar_i(ar_i),
	.ar_ready_o(ar_ready_o),
	.b_valid_o(b_valid_o),
	.b_o(b_o),
	.b_ready_i(b_ready_i),
	.r_valid_o(r_valid_o),
	.r_o(r_o),
	.r_ready_i(r_ready_i),
	.rd_data_i(rd_data),
	.req_o(req)
);

for (genvar k = 0; k < PORT_NUM; k++) begin : g_port
	mps_uart_port #(
		.PORT_ID(k),
		.FIFO_DEPTH(FIFO_DEPTH),
		.RESET_DIV(RESET_DIV)
	) port_i (
		.aclk(aclk),
		.rstni(rstni),
		.req_i(req),
		.rxd_i(rxd_i[k]),
		.rsp_o(port_rsp[k]),
		.txd_o(txd_o[k]),
		.irq_o(port_irq[k])
	);
end

mps_read_merge #(.PORT_NUM(PORT_NUM)) merge_i (
	.aclk(aclk),
	.rstni(rstni),
	.req_i(req),
	.rsp_i(port_rsp),
	.irq_i(port_irq),
	.rd_data_o(rd_data),
	.intr_o(intr_o)
);

endmodule

//--- sim/mps_tb.sv
`timescale 1ns/1ns

module mps_tb import mps_bus_pkg::*; import mps_uart_pkg::*; ();

localparam int PORT_NUM = 4;
localparam int FIFO_DEPTH = 4;
localparam int RESET_DIV = 16;
localparam int TMO = 4000; // Cycles per wait loop

logic aclk;
logic rstni;
logic aw_valid;
axil_aw_t aw;
logic aw_ready;
logic ar_valid;
axil_ar_t ar;
logic ar_ready;
logic b_valid;
axil_b_t b;
logic b_ready;
logic r_valid;
axil_r_t r;
logic r_ready;
logic [PORT_NUM-1:0] rxd;
logic [PORT_NUM-1:0] txd;
logic intr;
logic [PORT_NUM-1:0] loop_sel;
logic [PORT_NUM-1:0] drv_rxd;
logic [15:0] lfsr = 16'd22;
int checks = 0;
int errors = 0;
int tests = 0;
int tests_failed = 0;

assign rxd = (loop_sel & txd) | (~loop_sel & drv_rxd); // Loopback or bit-banger

initial begin
	aclk = 1'b0;
	forever #20 aclk = ~aclk;
end

mps_top #(.PORT_NUM(PORT_NUM), .FIFO_DEPTH(FIFO_DEPTH), .RESET_DIV(RESET_DIV)) dut_i (
	.aclk(aclk),
	.rstni(rstni),
	.aw_valid_i(aw_valid),
	.aw_i(aw),
	.aw_ready_o(aw_ready),
	.ar_valid_i(ar_valid),
	.ar_i(ar),
	.ar_ready_o(ar_ready),
	.b_valid_o(b_valid),
	.b_o(b),
	.b_ready_i(b_ready),
	.r_valid_o(r_valid),
	.r_o(r),
	.r_ready_i(r_ready),
	.rxd_i(rxd),
	.txd_o(txd),
	.intr_o(intr)
);

task automatic flag_error(input string msg);
	errors++;
	$display("%s at %0t ns", msg, $time);
endtask

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	assert (act === exp)
	else begin
		errors++;
		$display("Fail %s expected %h got %h", name, exp, act);
	end
endtask

a_read_latency: assert property (@(posedge aclk) disable iff (!rstni)
	ar_valid && ar_ready |-> ##1 !r_valid ##1 !r_valid ##1 r_valid)
	else flag_error("read response did not arrive 3 cycles after the address");
a_write_latency: assert property (@(posedge aclk) disable iff (!rstni)
	aw_valid && aw_ready |-> ##1 !b_valid ##1 b_valid)
	else flag_error("write response did not arrive 2 cycles after the address");
a_r_hold: assert property (@(posedge aclk) disable iff (!rstni)
	r_valid && !r_ready |=> r_valid && $stable(r))
	else flag_error("read response changed while the host stalled it");
a_b_hold: assert property (@(posedge aclk) disable iff (!rstni)
	b_valid && !b_ready |=> b_valid && $stable(b))
	else flag_error("write response changed while the host stalled it");
a_no_ready: assert property (@(posedge aclk) disable iff (!rstni)
	(b_valid || r_valid) |-> !aw_ready && !ar_ready)
	else flag_error("a ready output was high while a response was pending");

function automatic logic [31:0] reg_addr(input int port, input reg_sel_e sel);
	return {24'h0, 4'(port), sel, 2'b00};
endfunction

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic logic [7:0] rand_byte();
	logic [7:0] v;
	for (int i = 0; i < 8; i++) begin
		v[i] = lfsr[0];
		lfsr = lfsr_step(lfsr);
	end
	return v;
endfunction

task automatic axil_write(input logic [31:0] addr, input logic [31:0] data, input int hold,
		output logic [1:0] resp);
	int t;
	int n;
	aw_valid <= 1'b1;
	aw <= '{addr: addr, data: data, strb: 4'hf};
	b_ready <= (hold == 0);
	t = 0;
	do begin
		@(posedge aclk);
		t++;
	end while (!aw_ready && t < TMO);
	aw_valid <= 1'b0;
	if (!aw_ready)
		flag_error("write address was never accepted");
	t = 0;
	n = 0;
	do begin
		@(posedge aclk);
		t++;
		if (b_valid)
			n++;
		if (n >= hold)
			b_ready <= 1'b1; // Release after the stall
	end while (!(b_valid && b_ready) && t < TMO);
	resp = b.resp;
	b_ready <= 1'b0;
	if (!(b_valid && b_ready))
		flag_error("write response never came");
endtask

task automatic axil_read(input logic [31:0] addr, input int hold,
		output logic [31:0] data, output logic [1:0] resp);
	int t;
	int n;
	ar_valid <= 1'b1;
	ar <= '{addr: addr};
	r_ready <= (hold == 0);
	t = 0;
	do begin
		@(posedge aclk);
		t++;
	end while (!ar_ready && t < TMO);
	ar_valid <= 1'b0;
	if (!ar_ready)
		flag_error("read address was never accepted");
	t = 0;
	n = 0;
	do begin
		@(posedge aclk);
		t++;
		if (r_valid)
			n++;
		if (n >= hold)
			r_ready <= 1'b1;
	end while (!(r_valid && r_ready) && t < TMO);
	data = r.data;
	resp = r.resp;
	r_ready <= 1'b0;
	if (!(r_valid && r_ready))
		flag_error("read response never came");
endtask

// One 8N1 frame on rxd_i, then one idle bit
task automatic send_frame(input int p, input logic [7:0] data, input logic stop, input int div);
	logic [9:0] bits;
	bits = {stop, data, 1'b0};
	for (int i = 0; i < 10; i++) begin
		drv_rxd[p] <= bits[i];
		repeat (div) @(posedge aclk);
	end
	drv_rxd[p] <= 1'b1;
	repeat (div) @(posedge aclk);
endtask

task automatic capture_frame(input int p, input int div, output logic [9:0] bits);
	int t;
	t = 0;
	do begin
		@(posedge aclk);
		t++;
	end while (txd[p] && t < TMO);
	if (txd[p])
		flag_error("no start bit appeared on txd_o");
	repeat (div / 2 - 1) @(posedge aclk); // Middle of the start bit
	for (int i = 0; i < 10; i++) begin
		bits[i] = txd[p];
		repeat (div) @(posedge aclk);
	end
endtask

task automatic wait_status(input int p, input logic [15:0] mask);
	logic [31:0] d;
	logic [1:0] rs;
	int t;
	t = 0;
	do begin
		axil_read(reg_addr(p, REG_STATUS), 0, d, rs);
		t++;
	end while ((d[15:0] & mask) != mask && t < TMO / 8);
	if ((d[15:0] & mask) != mask)
		flag_error($sformatf("port %0d STATUS never showed %h", p, mask));
endtask

task automatic wait_intr(input logic level);
	int t;
	t = 0;
	while (intr !== level && t < TMO) begin
		@(posedge aclk);
		t++;
	end
	if (intr !== level)
		flag_error($sformatf("intr_o did not go to %0d in time", level));
endtask

task automatic end_test(input string name, input int err_before);
	tests++;
	if (errors > err_before)
		tests_failed++;
	$display("test %0d %s: %s", tests, name, (errors > err_before) ? "errors" : "ok");
endtask

initial begin
	logic [31:0] d;
	logic [1:0] rs;
	logic [9:0] frame;
	logic [7:0] sent [PORT_NUM][FIFO_DEPTH];
	logic [7:0] by;
	int e0;
	rstni <= 1'b0;
	aw_valid <= 1'b0;
	aw <= '0;
	ar_valid <= 1'b0;
	ar <= '0;
	b_ready <= 1'b0;
	r_ready <= 1'b0;
	loop_sel <= '0;
	drv_rxd <= '1;
	repeat (10) @(posedge aclk);
	rstni <= 1'b1;
	@(posedge aclk);

	e0 = errors;
	for (int k = 0; k < PORT_NUM; k++) begin
		axil_read(reg_addr(k, REG_STATUS), 0, d, rs);
		check_val($sformatf("r_o.data STATUS port %0d", k), 32'h4, d);
		axil_read(reg_addr(k, REG_DIV), 0, d, rs);
		check_val($sformatf("r_o.data DIV port %0d", k), RESET_DIV, d);
		axil_read(reg_addr(k, REG_CTRL), 0, d, rs);
		check_val($sformatf("r_o.data CTRL port %0d", k), 0, d);
	end
	axil_read(reg_addr(PORT_NUM, REG_DATA), 0, d, rs);
	check_val("r_o.data global", 0, d);
	check_val("txd_o", {PORT_NUM{1'b1}}, txd);
	check_val("intr_o", 0, intr);
	end_test("reset state", e0);

	e0 = errors;
	axil_write(reg_addr(0, REG_DIV), 8, 0, rs);
	by = rand_byte();
	fork
		axil_write(reg_addr(0, REG_DATA), by, 0, rs);
		capture_frame(0, 8, frame);
	join
	check_val("txd_o[0] frame", {1'b1, by, 1'b0}, frame);
	end_test("transmit framing", e0);

	e0 = errors;
	loop_sel <= '1;
	for (int k = 0; k < PORT_NUM; k++) begin
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			sent[k][i] = rand_byte();
			axil_write(reg_addr(k, REG_DATA), sent[k][i], 0, rs);
		end
	end
	for (int k = 0; k < PORT_NUM; k++)
		wait_status(k, 16'h4);
	for (int k = 0; k < PORT_NUM; k++) begin
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			axil_read(reg_addr(k, REG_DATA), 0, d, rs);
			check_val($sformatf("r_o.data DATA port %0d byte %0d", k, i), sent[k][i], d);
		end
		axil_read(reg_addr(k, REG_STATUS), 0, d, rs);
		check_val($sformatf("r_o.data STATUS port %0d", k), 32'h4, d);
	end
	end_test("loopback and FIFO order", e0);

	e0 = errors;
	loop_sel[1] <= 1'b0;
	by = rand_byte();
	send_frame(1, by, 1'b0, RESET_DIV); // Low stop bit
	axil_read(reg_addr(1, REG_STATUS), 0, d, rs);
	check_val("r_o.data STATUS frame_err set", 32'hD, d);
	axil_read(reg_addr(1, REG_STATUS), 0, d, rs);
	check_val("r_o.data STATUS frame_err clear", 32'h5, d);
	axil_read(reg_addr(1, REG_DATA), 0, d, rs);
	check_val("r_o.data DATA with frame error", {23'b0, 1'b1, by}, d);
	for (int i = 0; i <= FIFO_DEPTH; i++) begin
		by = rand_byte();
		if (i < FIFO_DEPTH)
			sent[1][i] = by;
		send_frame(1, by, 1'b1, RESET_DIV);
	end
	axil_read(reg_addr(1, REG_STATUS), 0, d, rs);
	check_val("r_o.data STATUS rx_overrun set", 32'h15, d);
	axil_read(reg_addr(1, REG_STATUS), 0, d, rs);
	check_val("r_o.data STATUS rx_overrun clear", 32'h5, d);
	for (int i = 0; i < FIFO_DEPTH; i++) begin
		axil_read(reg_addr(1, REG_DATA), 0, d, rs);
		check_val($sformatf("r_o.data DATA port 1 byte %0d", i), sent[1][i], d);
	end
	axil_read(reg_addr(1, REG_STATUS), 0, d, rs);
	check_val("r_o.data STATUS port 1 drained", 32'h4, d);
	end_test("line errors", e0);

	e0 = errors;
	loop_sel[2] <= 1'b0;
	axil_write(reg_addr(2, REG_CTRL), 32'h1, 0, rs);
	check_val("intr_o before byte", 0, intr);
	by = rand_byte();
	send_frame(2, by, 1'b1, RESET_DIV);
	wait_intr(1'b1);
	axil_read(reg_addr(PORT_NUM, REG_DATA), 0, d, rs);
	check_val("r_o.data global", 32'h4, d);
	axil_read(reg_addr(2, REG_DATA), 0, d, rs);
	check_val("r_o.data DATA port 2", by, d);
	axil_read(reg_addr(PORT_NUM, REG_DATA), 0, d, rs);
	check_val("r_o.data global after read", 0, d);
	check_val("intr_o after read", 0, intr);
	axil_write(reg_addr(2, REG_CTRL), 32'h0, 0, rs);
	axil_write(reg_addr(2, REG_DATA), rand_byte(), 0, rs);
	axil_write(reg_addr(2, REG_CTRL), 32'h2, 0, rs);
	check_val("intr_o while sending", 0, intr);
	wait_intr(1'b1);
	axil_read(reg_addr(2, REG_STATUS), 0, d, rs);
	check_val("r_o.data STATUS port 2", 32'h4, d);
	axil_write(reg_addr(2, REG_CTRL), 32'h0, 0, rs);
	wait_intr(1'b0);
	end_test("interrupts", e0);

	e0 = errors;
	axil_read(reg_addr(5, REG_DIV), 0, d, rs);
	check_val("r_o.resp port 5 read", RESP_SLVERR, rs);
	check_val("r_o.data port 5 read", 0, d);
	axil_write(reg_addr(5, REG_DIV), 32'h3, 0, rs);
	check_val("b_o.resp port 5 write", RESP_SLVERR, rs);
	axil_write(reg_addr(PORT_NUM, REG_DATA), 32'h1, 0, rs);
	check_val("b_o.resp global write", RESP_SLVERR, rs);
	axil_read(reg_addr(PORT_NUM, REG_STATUS), 0, d, rs);
	check_val("r_o.resp undefined index", RESP_OKAY, rs);
	check_val("r_o.data undefined index", 0, d);
	axil_write(reg_addr(3, REG_DIV), 32'h21, 6, rs); // Stalled response
	check_val("b_o.resp stalled write", RESP_OKAY, rs);
	axil_read(reg_addr(3, REG_DIV), 6, d, rs);
	check_val("r_o.resp stalled read", RESP_OKAY, rs);
	check_val("r_o.data stalled read", 32'h21, d);
	end_test("bus protocol", e0);

	$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, tests_failed, checks,
		errors);
	if (errors == 0)
		$display("TESTBENCH PASSED");
	else
		$display("TESTBENCH FAILED");
	$finish;
end

endmodule

//--- compile.f
design/mps_bus_pkg.sv
design/mps_uart_pkg.sv
design/mps_sync_fifo.sv
design/mps_axil_front.sv
design/mps_uart_port.sv
design/mps_read_merge.sv
design/mps_top.sv
sim/mps_tb.sv
